//--- dispatchRouter.sv
`timescale 1ns/1ps

module dispatchRouter import rvDecodePkg::*; #(
    parameter int addrWidth = 32
) (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic                   rdy,
    input  logic                   icValid,
    input  logic [instWidth-1:0]   inst,
    input  logic [addrWidth-1:0]   pc,
    input  logic                   predJumpIn,
    input  logic [addrWidth-1:0]   predPcIn,
    input  instClass_e             instClass,
    input  opId_e                  opIdIn,
    input  logic                   legal,
    input  logic [immWidth-1:0]    immIn,
    // Consumer valids
    output logic                   lsbValid,
    output logic                   rsValid,
    output logic                   robValid,
    output logic                   rfRdValid,
    output logic                   rfRs1Valid,
    output logic                   rfRs2Valid,
    // Shared payload
    output logic [addrWidth-1:0]   instPc,
    output opId_e                  opId,
    output logic [regIdxWidth-1:0] rd,
    output logic [regIdxWidth-1:0] rs1,
    output logic [regIdxWidth-1:0] rs2,
    output logic [immWidth-1:0]    imm,
    output logic                   predJump,
    output logic [addrWidth-1:0]   predPc
);

    logic                 accept;
    logic                 toLsb;
    logic                 toRs;
    logic                 needRd;
    logic                 needRs1;
    logic                 needRs2;
    logic                 isCtrl;
    logic [addrWidth-1:0] pcPlus4;

    // Illegal words are dropped like an empty slot
    assign accept = icValid && legal;

    // Routing table per class
    always_comb begin
        toLsb   = 1'b0;
        toRs    = 1'b0;
        needRd  = 1'b0;
        needRs1 = 1'b0;
        needRs2 = 1'b0;
        case (instClass)
            clsLui, clsAuipc, clsJal: begin
                toRs   = 1'b1;
                needRd = 1'b1;
            end
            clsJalr, clsAluImm: begin
                toRs    = 1'b1;
                needRd  = 1'b1;
                needRs1 = 1'b1;
            end
            clsBranch: begin
                toRs    = 1'b1;
                needRs1 = 1'b1;
                needRs2 = 1'b1;
            end
            clsLoad: begin
                toLsb   = 1'b1;
                needRd  = 1'b1;
                needRs1 = 1'b1;
            end
            clsStore: begin
                toLsb   = 1'b1;
                needRs1 = 1'b1;
                needRs2 = 1'b1;
            end
            clsAluReg: begin
                toRs    = 1'b1;
                needRd  = 1'b1;
                needRs1 = 1'b1;
                needRs2 = 1'b1;
            end
            default: toRs = 1'b0;
        endcase
    end

    // Only control flow keeps the predictor's guess
    assign isCtrl  = (instClass == clsJal) || (instClass == clsJalr) ||
                     (instClass == clsBranch);
    assign pcPlus4 = pc + addrWidth'(4);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            lsbValid   <= 1'b0;
            rsValid    <= 1'b0;
            robValid   <= 1'b0;
            rfRdValid  <= 1'b0;
            rfRs1Valid <= 1'b0;
            rfRs2Valid <= 1'b0;
            instPc     <= '0;
            opId       <= opNop;
            rd         <= '0;
            rs1        <= '0;
            rs2        <= '0;
            imm        <= '0;
            predJump   <= 1'b0;
            predPc     <= '0;
        end else if (rdy) begin
            // Valids refresh every ready cycle, idle clears them
            lsbValid   <= accept && toLsb;
            rsValid    <= accept && toRs;
            // Every routed instruction takes a ROB entry
            robValid   <= accept && (toLsb || toRs);
            rfRdValid  <= accept && needRd;
            rfRs1Valid <= accept && needRs1;
            rfRs2Valid <= accept && needRs2;
            if (accept) begin
                instPc   <= pc;
                opId     <= opIdIn;
                // Unused indices forced to x0
                rd       <= needRd  ? inst[11:7]  : '0;
                rs1      <= needRs1 ? inst[19:15] : '0;
                rs2      <= needRs2 ? inst[24:20] : '0;
                imm      <= immIn;
                predJump <= isCtrl ? predJumpIn : 1'b0;
                predPc   <= isCtrl ? predPcIn   : pcPlus4;
            end
        end
    end

endmodule

//--- immGen.sv
`timescale 1ns/1ps

module immGen import rvDecodePkg::*; (
    input  logic [instWidth-1:0] inst,
    input  instClass_e           instClass,
    output logic [immWidth-1:0]  imm
);

    logic [2:0] funct3;
    logic       isShift;

    assign funct3 = inst[14:12];

    // SLLI, SRLI and SRAI carry a shift amount, not a signed value
    assign isShift = (funct3 == f3Sll) || (funct3 == f3Srl);

    always_comb begin
        case (instClass)
            // U type, low 12 bits zero
            clsLui, clsAuipc:
                imm = {inst[31:12], {(immWidth-20){1'b0}}};
            // J type, bit 0 implied
            clsJal:
                imm = {{(immWidth-20){inst[31]}}, inst[19:12], inst[20],
                       inst[30:21], 1'b0};
            // B type, bit 0 implied
            clsBranch:
                imm = {{(immWidth-12){inst[31]}}, inst[7], inst[30:25],
                       inst[11:8], 1'b0};
            // I type
            clsJalr, clsLoad:
                imm = {{(immWidth-12){inst[31]}}, inst[31:20]};
            // S type, split field
            clsStore:
                imm = {{(immWidth-12){inst[31]}}, inst[31:25], inst[11:7]};
            clsAluImm: begin
                if (isShift) begin
                    imm = {{(immWidth-6){1'b0}}, inst[25:20]};
                end else begin
                    imm = {{(immWidth-12){inst[31]}}, inst[31:20]};
                end
            end
            // Register ALU and unknown carry no immediate
            default:
                imm = '0;
        endcase
    end

endmodule

//--- instDecoder.sv
`timescale 1ns/1ps

module instDecoder import rvDecodePkg::*; #(
    parameter int addrWidth = 32
) (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic                   rdy,
    // Fetch side
    input  logic                   icValid,
    input  logic [instWidth-1:0]   icInst,
    input  logic [addrWidth-1:0]   icPc,
    input  logic                   icPredJump,
    input  logic [addrWidth-1:0]   icPredPc,
    // Per-consumer valids
    output logic                   lsbValid,
    output logic                   rsValid,
    output logic                   robValid,
    output logic                   rfRdValid,
    output logic                   rfRs1Valid,
    output logic                   rfRs2Valid,
    // Payload shared by all consumers
    output logic [addrWidth-1:0]   instPc,
    output opId_e                  opId,
    output logic [regIdxWidth-1:0] rd,
    output logic [regIdxWidth-1:0] rs1,
    output logic [regIdxWidth-1:0] rs2,
    output logic [immWidth-1:0]    imm,
    output logic                   predJump,
    output logic [addrWidth-1:0]   predPc
);

    instClass_e            instClass;
    opId_e                 opIdComb;
    logic                  legal;
    logic [immWidth-1:0]   immComb;

    // Class and operation from opcode and funct fields
    opDecoder opDecoder_inst (
        .inst      (icInst),
        .instClass (instClass),
        .opId      (opIdComb),
        .legal     (legal)
    );

    // Immediate per format
    immGen immGen_inst (
        .inst      (icInst),
        .instClass (instClass),
        .imm       (immComb)
    );

    // Registered dispatch stage
    dispatchRouter #(
        .addrWidth (addrWidth)
    ) dispatchRouter_inst (
        .clk        (clk),
        .arstN      (arstN),
        .rdy        (rdy),
        .icValid    (icValid),
        .inst       (icInst),
        .pc         (icPc),
        .predJumpIn (icPredJump),
        .predPcIn   (icPredPc),
        .instClass  (instClass),
        .opIdIn     (opIdComb),
        .legal      (legal),
        .immIn      (immComb),
        .lsbValid   (lsbValid),
        .rsValid    (rsValid),
        .robValid   (robValid),
        .rfRdValid  (rfRdValid),
        .rfRs1Valid (rfRs1Valid),
        .rfRs2Valid (rfRs2Valid),
        .instPc     (instPc),
        .opId       (opId),
        .rd         (rd),
        .rs1        (rs1),
        .rs2        (rs2),
        .imm        (imm),
        .predJump   (predJump),
        .predPc     (predPc)
    );

endmodule

//--- instDecoderTb.sv
`timescale 1ns/1ps

module instDecoderTb import rvDecodePkg::*; ();

    localparam int addrWidth     = 32;
    localparam int timeoutCycles = 8;
    // Table index where rdy drops for a few cycles
    localparam int stallAt       = 12;

    // Expected valids {lsb, rs, rob, rd, rs1, rs2} per class
    localparam logic [5:0] vUpper  = 6'b011100;
    localparam logic [5:0] vJalr   = 6'b011110;
    localparam logic [5:0] vBranch = 6'b011011;
    localparam logic [5:0] vLoad   = 6'b101110;
    localparam logic [5:0] vStore  = 6'b101011;
    localparam logic [5:0] vReg    = 6'b011111;
    localparam logic [5:0] vImm    = 6'b011110;

    typedef struct packed {
        logic                 valid;
        logic [instWidth-1:0] inst;
        logic [5:0]           vld;
        opId_e                op;
        logic [immWidth-1:0]  imm;
        logic                 ctrl;
    } entry_t;

    logic clk, arstN, rdy, icValid, icPredJump;
    logic [instWidth-1:0] icInst;
    logic [addrWidth-1:0] icPc, icPredPc;
    logic lsbValid, rsValid, robValid, rfRdValid, rfRs1Valid, rfRs2Valid;
    logic [addrWidth-1:0] instPc, predPc;
    opId_e opId;
    logic [regIdxWidth-1:0] rd, rs1, rs2;
    logic [immWidth-1:0] imm;
    logic predJump;

    entry_t stimTable[$];

    instDecoder #(.addrWidth(addrWidth)) instDecoder_inst (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic checkValue(input logic [127:0] actual, input logic [127:0] expected,
                              input string what);
        if (actual !== expected) begin
            $display("MISMATCH at %0t ns: %s is %0h, expected %0h", $time, what, actual,
                     expected);
            $display(">>> FAIL");
            $fatal(1, "Output check failed");
        end
    endtask

    // Branch word with rs1 = x4, rs2 = x3 and the B-type offset scattered
    function automatic logic [instWidth-1:0] encBranch(input logic [12:0] off,
                                                       input logic [2:0] f3);
        return {off[12], off[10:5], 5'd3, 5'd4, f3, off[4:1], off[11], opcBranch};
    endfunction

    function automatic logic [5:0] validBits();
        return {lsbValid, rsValid, robValid, rfRdValid, rfRs1Valid, rfRs2Valid};
    endfunction

    function automatic logic [127:0] outputState();
        return 128'({validBits(), instPc, opId, rd, rs1, rs2, imm, predJump, predPc});
    endfunction

    task automatic addEntry(input logic v, input logic [instWidth-1:0] w, input logic [5:0] vl,
                            input opId_e o, input logic [immWidth-1:0] im, input logic c);
        stimTable.push_back('{v, w, vl, o, im, c});
    endtask

    task automatic waitForDispatch(output int cycles);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!robValid && cycles < timeoutCycles);
        if (!robValid) begin
            $display("Timeout: no dispatch within %0d cycles", cycles);
            $display(">>> FAIL");
            $fatal(1, "Dispatch timeout");
        end
    endtask

    // Drive one entry, then compare outputs a cycle later
    task automatic applyEntry(input entry_t e);
        logic [31:0] pcRand;
        logic [31:0] predRand;
        int cycles;
        pcRand     = $urandom();
        predRand   = $urandom();
        icValid    = e.valid;
        icInst     = e.inst;
        icPc       = {pcRand[31:2], 2'b00};
        icPredJump = predRand[0];
        icPredPc   = {predRand[31:2], 2'b00};
        if (e.vld[3]) begin
            waitForDispatch(cycles);
            checkValue(128'(cycles), 128'd1, "dispatch latency");
        end else begin
            @(negedge clk);
        end
        checkValue(128'(validBits()), 128'(e.vld), "valids");
        if (e.vld != 6'b0) begin
            checkValue(128'(opId), 128'(e.op), "opId");
            checkValue(128'(imm), 128'(e.imm), "imm");
            checkValue(128'(instPc), 128'(icPc), "instPc");
            // Branch and store carry no destination
            checkValue(128'(rd), 128'(e.vld[2] ? e.inst[11:7] : 5'd0), "rd");
            if (e.vld[1]) begin
                checkValue(128'(rs1), 128'(e.inst[19:15]), "rs1");
            end
            if (e.vld[0]) begin
                checkValue(128'(rs2), 128'(e.inst[24:20]), "rs2");
            end
            checkValue(128'(predJump), 128'(e.ctrl ? icPredJump : 1'b0), "predJump");
            checkValue(128'(predPc), 128'(e.ctrl ? icPredPc : icPc + 32'd4), "predPc");
        end
    endtask

    // Hold rdy low with a fresh word waiting, outputs must not move
    task automatic holdStall();
        logic [127:0] held;
        held    = outputState();
        rdy     = 1'b0;
        icValid = 1'b1;
        icInst  = {12'h123, 5'd7, f3Add, 5'd9, opcAluImm};
        repeat (4) begin
            @(negedge clk);
            checkValue(outputState(), held, "output during stall");
        end
        rdy = 1'b1;
    endtask

    task automatic buildTable();
        addEntry(1'b1, {20'hABCDE, 5'd5, opcLui}, vUpper, opLui, 32'hABCD_E000, 1'b0);
        addEntry(1'b1, {20'h80001, 5'd5, opcAuipc}, vUpper, opAuipc, 32'h8000_1000, 1'b0);
        addEntry(1'b1, {1'b1, 10'h000, 1'b1, 8'hFF, 5'd5, opcJal}, vUpper, opJal,
                 32'hFFFF_F800, 1'b1);
        addEntry(1'b1, {12'hFF0, 5'd6, f3Jalr, 5'd5, opcJalr}, vJalr, opJalr, 32'hFFFF_FFF0, 1'b1);
        addEntry(1'b1, encBranch(13'h1FFC, f3Beq), vBranch, opBeq, 32'hFFFF_FFFC, 1'b1);
        addEntry(1'b1, encBranch(13'h0008, f3Bne), vBranch, opBne, 32'h0000_0008, 1'b1);
        addEntry(1'b1, encBranch(13'h1FFC, f3Blt), vBranch, opBlt, 32'hFFFF_FFFC, 1'b1);
        addEntry(1'b1, encBranch(13'h0FFE, f3Bge), vBranch, opBge, 32'h0000_0FFE, 1'b1);
        addEntry(1'b1, encBranch(13'h1000, f3Bltu), vBranch, opBltu, 32'hFFFF_F000, 1'b1);
        addEntry(1'b1, encBranch(13'h0010, f3Bgeu), vBranch, opBgeu, 32'h0000_0010, 1'b1);
        addEntry(1'b1, {12'h7FF, 5'd6, f3Lb, 5'd5, opcLoad}, vLoad, opLb, 32'h0000_07FF, 1'b0);
        addEntry(1'b1, {12'h800, 5'd6, f3Lh, 5'd5, opcLoad}, vLoad, opLh, 32'hFFFF_F800, 1'b0);
        addEntry(1'b1, {12'h004, 5'd6, f3Lw, 5'd5, opcLoad}, vLoad, opLw, 32'h0000_0004, 1'b0);
        addEntry(1'b1, {12'hFFF, 5'd6, f3Lbu, 5'd5, opcLoad}, vLoad, opLbu, 32'hFFFF_FFFF, 1'b0);
        addEntry(1'b1, {12'h010, 5'd6, f3Lhu, 5'd5, opcLoad}, vLoad, opLhu, 32'h0000_0010, 1'b0);
        addEntry(1'b1, {7'h7F, 5'd7, 5'd6, f3Sb, 5'h1E, opcStore}, vStore, opSb, 32'hFFFF_FFFE,
                 1'b0);
        addEntry(1'b1, {7'h01, 5'd7, 5'd6, f3Sh, 5'h00, opcStore}, vStore, opSh, 32'h20, 1'b0);
        addEntry(1'b1, {7'h00, 5'd7, 5'd6, f3Sw, 5'h0C, opcStore}, vStore, opSw, 32'h0C, 1'b0);
        addEntry(1'b1, {f7Base, 5'd7, 5'd6, f3Add, 5'd5, opcAluReg}, vReg, opAdd, 32'h0, 1'b0);
        addEntry(1'b1, {f7Sub, 5'd7, 5'd6, f3Add, 5'd5, opcAluReg}, vReg, opSub, 32'h0, 1'b0);
        addEntry(1'b1, {f7Base, 5'd7, 5'd6, f3Sll, 5'd5, opcAluReg}, vReg, opSll, 32'h0, 1'b0);
        addEntry(1'b1, {f7Base, 5'd7, 5'd6, f3Slt, 5'd5, opcAluReg}, vReg, opSlt, 32'h0, 1'b0);
        addEntry(1'b1, {f7Base, 5'd7, 5'd6, f3Sltu, 5'd5, opcAluReg}, vReg, opSltu, 32'h0, 1'b0);
        addEntry(1'b1, {f7Base, 5'd7, 5'd6, f3Xor, 5'd5, opcAluReg}, vReg, opXor, 32'h0, 1'b0);
        addEntry(1'b1, {f7Base, 5'd7, 5'd6, f3Srl, 5'd5, opcAluReg}, vReg, opSrl, 32'h0, 1'b0);
        addEntry(1'b1, {f7Sra, 5'd7, 5'd6, f3Srl, 5'd5, opcAluReg}, vReg, opSra, 32'h0, 1'b0);
        addEntry(1'b1, {f7Base, 5'd7, 5'd6, f3Or, 5'd5, opcAluReg}, vReg, opOr, 32'h0, 1'b0);
        addEntry(1'b1, {f7Base, 5'd7, 5'd6, f3And, 5'd5, opcAluReg}, vReg, opAnd, 32'h0, 1'b0);
        addEntry(1'b1, {12'hFFF, 5'd6, f3Add, 5'd5, opcAluImm}, vImm, opAddi, 32'hFFFF_FFFF, 1'b0);
        addEntry(1'b1, {12'h123, 5'd6, f3Slt, 5'd5, opcAluImm}, vImm, opSlti, 32'h123, 1'b0);
        addEntry(1'b1, {12'h800, 5'd6, f3Sltu, 5'd5, opcAluImm}, vImm, opSltiu, 32'hFFFF_F800,
                 1'b0);
        addEntry(1'b1, {12'h0AA, 5'd6, f3Xor, 5'd5, opcAluImm}, vImm, opXori, 32'hAA, 1'b0);
        addEntry(1'b1, {12'hF00, 5'd6, f3Or, 5'd5, opcAluImm}, vImm, opOri, 32'hFFFF_FF00, 1'b0);
        addEntry(1'b1, {12'h0FF, 5'd6, f3And, 5'd5, opcAluImm}, vImm, opAndi, 32'hFF, 1'b0);
        // Shift amounts come back zero-extended
        addEntry(1'b1, {7'h00, 5'd31, 5'd6, f3Sll, 5'd5, opcAluImm}, vImm, opSlli, 32'h1F, 1'b0);
        addEntry(1'b1, {7'h00, 5'd5, 5'd6, f3Srl, 5'd5, opcAluImm}, vImm, opSrli, 32'h5, 1'b0);
        addEntry(1'b1, {7'h20, 5'd7, 5'd6, f3Srl, 5'd5, opcAluImm}, vImm, opSrai, 32'h7, 1'b0);
        // Unknown opcode, then a multiply funct7, then an idle slot
        addEntry(1'b1, 32'h0000_007F, 6'b0, opNop, 32'h0, 1'b0);
        addEntry(1'b1, {7'h01, 5'd7, 5'd6, f3Add, 5'd5, opcAluReg}, 6'b0, opNop, 32'h0, 1'b0);
        addEntry(1'b0, {12'h001, 5'd6, f3Add, 5'd5, opcAluImm}, 6'b0, opNop, 32'h0, 1'b0);
    endtask

    initial begin
        void'($urandom(32'h41b0_04f4));
        arstN      = 1'b0;
        rdy        = 1'b1;
        icValid    = 1'b0;
        icInst     = '0;
        icPc       = '0;
        icPredJump = 1'b0;
        icPredPc   = '0;
        buildTable();
        repeat (5) begin
            @(negedge clk);
            checkValue(128'(validBits()), 128'd0, "valids in reset");
        end
        arstN = 1'b1;
        @(negedge clk);
        checkValue(128'(validBits()), 128'd0, "valids after reset");
        foreach (stimTable[i]) begin
            if (i == stallAt) begin
                holdStall();
            end
            applyEntry(stimTable[i]);
        end
        // Bound assertions count their own failures
        if (instDecoder_inst.dispatchRouter_inst.dispatchRules_inst.failCount == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            $display("Dispatch assertions failed during the run");
            $display(">>> FAIL");
            $fatal(1, "Assertion failures");
        end
    end

endmodule

//--- instDecoderTb_assert.sv
`timescale 1ns/1ps

module dispatchRules (
    input logic clk,
    input logic arstN,
    input logic rdy,
    input logic icValid,
    input logic legal,
    input logic lsbValid,
    input logic rsValid,
    input logic robValid,
    input logic rfRdValid,
    input logic rfRs1Valid,
    input logic rfRs2Valid
);

    int   failCount = 0;
    logic anyValid;

    assign anyValid = lsbValid | rsValid | robValid | rfRdValid | rfRs1Valid | rfRs2Valid;

    // Memory ops and compute ops go to different queues
    lsbRsExclusive: assert property (@(posedge clk) disable iff (!arstN)
        !(lsbValid && rsValid))
        else begin
            failCount++;
            $error("lsbValid and rsValid high together");
        end

    // ROB entry for every routed instruction
    robMatchesRoute: assert property (@(posedge clk) disable iff (!arstN)
        robValid == (lsbValid || rsValid))
        else begin
            failCount++;
            $error("robValid does not follow lsbValid or rsValid");
        end

    // A rising valid needs an accepted word one edge back
    riseNeedsAccept: assert property (@(posedge clk) disable iff (!arstN)
        $rose(anyValid) |-> $past(rdy && icValid && legal))
        else begin
            failCount++;
            $error("valid rose without an accepted instruction");
        end

endmodule

bind dispatchRouter dispatchRules dispatchRules_inst (.*);

//--- opDecoder.sv
`timescale 1ns/1ps

module opDecoder import rvDecodePkg::*; (
    input  logic [instWidth-1:0] inst,
    output instClass_e           instClass,
    output opId_e                opId,
    output logic                 legal
);

    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    always_comb begin
        instClass = clsNone;
        opId      = opNop;
        case (opcode)
            opcLui:    begin instClass = clsLui;   opId = opLui;   end
            opcAuipc:  begin instClass = clsAuipc; opId = opAuipc; end
            opcJal:    begin instClass = clsJal;   opId = opJal;   end
            opcJalr: begin
                instClass = clsJalr;
                if (funct3 == f3Jalr) opId = opJalr;
            end
            opcBranch: begin
                instClass = clsBranch;
                case (funct3)
                    f3Beq:   opId = opBeq;
                    f3Bne:   opId = opBne;
                    f3Blt:   opId = opBlt;
                    f3Bge:   opId = opBge;
                    f3Bltu:  opId = opBltu;
                    f3Bgeu:  opId = opBgeu;
                    default: opId = opNop;
                endcase
            end
            opcLoad: begin
                instClass = clsLoad;
                case (funct3)
                    f3Lb:    opId = opLb;
                    f3Lh:    opId = opLh;
                    f3Lw:    opId = opLw;
                    f3Lbu:   opId = opLbu;
                    f3Lhu:   opId = opLhu;
                    default: opId = opNop;
                endcase
            end
            opcStore: begin
                instClass = clsStore;
                case (funct3)
                    f3Sb:    opId = opSb;
                    f3Sh:    opId = opSh;
                    f3Sw:    opId = opSw;
                    default: opId = opNop;
                endcase
            end
            opcAluReg: begin
                instClass = clsAluReg;
                case (funct3)
                    // Funct7 splits add/sub and the two right shifts
                    f3Add:  opId = (funct7 == f7Base) ? opAdd :
                                   (funct7 == f7Sub)  ? opSub : opNop;
                    f3Sll:  opId = opSll;
                    f3Slt:  opId = opSlt;
                    f3Sltu: opId = opSltu;
                    f3Xor:  opId = opXor;
                    f3Srl:  opId = (funct7 == f7Base) ? opSrl :
                                   (funct7 == f7Sra)  ? opSra : opNop;
                    f3Or:   opId = opOr;
                    f3And:  opId = opAnd;
                endcase
            end
            opcAluImm: begin
                instClass = clsAluImm;
                case (funct3)
                    f3Add:  opId = opAddi;
                    f3Sll:  opId = opSlli;
                    f3Slt:  opId = opSlti;
                    f3Sltu: opId = opSltiu;
                    f3Xor:  opId = opXori;
                    // Upper immediate bits pick logical or arithmetic
                    f3Srl:  opId = (funct7 == f7Base) ? opSrli :
                                   (funct7 == f7Sra)  ? opSrai : opNop;
                    f3Or:   opId = opOri;
                    f3And:  opId = opAndi;
                endcase
            end
            default: instClass = clsNone;
        endcase
    end

    // Anything that fell through to opNop is not a real instruction
    assign legal = (opId != opNop);

endmodule

//--- run.sh
#!/bin/sh
# Build with Verilator, run, then look for the pass line in sim.log
cd "$(dirname "$0")" &&
rm -f build.log sim.log &&
verilator --binary --timing --assert -f sources.f --top-module instDecoderTb \
    -o instDecoderSim > build.log 2>&1 &&
{ ./obj_dir/instDecoderSim > sim.log 2>&1 || true; } &&
grep -q '^>>> PASS$' sim.log && echo "Simulation passed" ||
{ echo "Simulation failed, see build.log and sim.log"; exit 1; }

//--- rvDecodePkg.sv
package rvDecodePkg;

    // Datapath widths
    localparam int instWidth   = 32;
    localparam int immWidth    = 32;
    localparam int regIdxWidth = 5;

    // Major opcodes, instruction bits 6:0
    typedef enum logic [6:0] {
        opcLui    = 7'b0110111,
        opcAuipc  = 7'b0010111,
        opcJal    = 7'b1101111,
        opcJalr   = 7'b1100111,
        opcBranch = 7'b1100011,
        opcLoad   = 7'b0000011,
        opcStore  = 7'b0100011,
        opcAluReg = 7'b0110011,
        opcAluImm = 7'b0010011
    } opcode_e;

    // Decoded class, clsNone for anything unknown
    typedef enum logic [3:0] {
        clsNone, clsLui, clsAuipc, clsJal, clsJalr,
        clsBranch, clsLoad, clsStore, clsAluReg, clsAluImm
    } instClass_e;

    // Operation id seen by every consumer
    typedef enum logic [5:0] {
        opNop,
        opLui, opAuipc, opJal, opJalr,
        opBeq, opBne, opBlt, opBge, opBltu, opBgeu,
        opLb, opLh, opLw, opLbu, opLhu,
        opSb, opSh, opSw,
        opAdd, opSub, opSll, opSlt, opSltu, opXor, opSrl, opSra, opOr, opAnd,
        opAddi, opSlti, opSltiu, opXori, opOri, opAndi, opSlli, opSrli, opSrai
    } opId_e;

    // Jump and link register
    localparam logic [2:0] f3Jalr = 3'b000;

    // Branch compares
    localparam logic [2:0] f3Beq  = 3'b000;
    localparam logic [2:0] f3Bne  = 3'b001;
    localparam logic [2:0] f3Blt  = 3'b100;
    localparam logic [2:0] f3Bge  = 3'b101;
    localparam logic [2:0] f3Bltu = 3'b110;
    localparam logic [2:0] f3Bgeu = 3'b111;

    // Load sizes
    localparam logic [2:0] f3Lb   = 3'b000;
    localparam logic [2:0] f3Lh   = 3'b001;
    localparam logic [2:0] f3Lw   = 3'b010;
    localparam logic [2:0] f3Lbu  = 3'b100;
    localparam logic [2:0] f3Lhu  = 3'b101;

    // Store sizes
    localparam logic [2:0] f3Sb   = 3'b000;
    localparam logic [2:0] f3Sh   = 3'b001;
    localparam logic [2:0] f3Sw   = 3'b010;

    // ALU ops, shared by register and immediate forms
    localparam logic [2:0] f3Add  = 3'b000;
    localparam logic [2:0] f3Sll  = 3'b001;
    localparam logic [2:0] f3Slt  = 3'b010;
    localparam logic [2:0] f3Sltu = 3'b011;
    localparam logic [2:0] f3Xor  = 3'b100;
    localparam logic [2:0] f3Srl  = 3'b101;
    localparam logic [2:0] f3Or   = 3'b110;
    localparam logic [2:0] f3And  = 3'b111;

    // Funct7 selectors
    localparam logic [6:0] f7Base = 7'b0000000;
    localparam logic [6:0] f7Sub  = 7'b0100000;
    localparam logic [6:0] f7Sra  = 7'b0100000;

endpackage

//--- sources.f
rvDecodePkg.sv
opDecoder.sv
immGen.sv
dispatchRouter.sv
instDecoder.sv
instDecoderTb_assert.sv
instDecoderTb.sv
